/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
LINTFLAGS = --lint-only --timing
TOP       = tb_ahb_out_stage
FILELIST  = ahb_out_stage.f
OBJ_DIR   = obj_dir
PASS_MSG  = All tests passed!

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qF "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

/* ahb_out_stage.f */
hw/ahb_pkg.sv
hw/mtx_pkg.sv
hw/ahb_out_arb.sv
hw/ahb_out_addr_mux.sv
hw/ahb_out_data_stage.sv
hw/ahb_out_stage.sv
tests/ahb_out_stage_props.sv
tests/tb_ahb_out_stage.sv

/* hw/ahb_out_addr_mux.sv */
// ----------------------------------------------------------------------
// Address-phase mux of the shared slave port and per-port active decode
// ----------------------------------------------------------------------

`timescale 1ns/1ns

module ahb_out_addr_mux
  import ahb_pkg::*, mtx_pkg::*;
(
  input  port_idx_t i_addr_port,                  // Address-phase grant
  input  logic      i_sel      [MTX_PORTS],       // Per-port HSEL
  input  haddr_t    i_addr     [MTX_PORTS],       // Per-port HADDR
  input  htrans_t   i_trans    [MTX_PORTS],       // Per-port HTRANS
  input  logic      i_write    [MTX_PORTS],       // Per-port HWRITE
  input  hsize_t    i_size     [MTX_PORTS],       // Per-port HSIZE
  input  hmaster_t  i_master   [MTX_PORTS],       // Per-port HMASTER
  input  logic      i_mastlock [MTX_PORTS],       // Per-port HMASTLOCK
  output logic      o_active   [MTX_PORTS],       // Port owns address phase
  output logic      o_hselm,                      // Slave select
  output haddr_t    o_haddrm,                     // Slave address
  output htrans_t   o_htransm,                    // Slave transfer type
  output logic      o_hwritem,                    // Slave direction
  output hsize_t    o_hsizem,                     // Slave transfer size
  output hmaster_t  o_hmasterm,                   // Slave master ID
  output logic      o_hmastlockm                  // Slave locked transfer
);

  // ----------------------------------------------------------------------
  // Active decode
  // ----------------------------------------------------------------------
  // PORT_NONE matches no index, all flags stay low
  always_comb
  begin
    for (int i = 0; i < MTX_PORTS; i++)
      o_active[i] = (i_addr_port == port_idx_t'(i));  // One-hot grant
  end

  // ----------------------------------------------------------------------
  // Address and control mux
  // ----------------------------------------------------------------------
  always_comb
  begin
    o_hselm      = 1'b0;                          // Idle bus by default
    o_haddrm     = '0;
    o_htransm    = HTRANS_IDLE;
    o_hwritem    = 1'b0;
    o_hsizem     = '0;
    o_hmasterm   = '0;
    o_hmastlockm = 1'b0;
    for (int i = 0; i < MTX_PORTS; i++)
    begin
      if (o_active[i])                            // Granted port only
      begin
        o_hselm      = i_sel[i];
        o_haddrm     = i_addr[i];
        o_htransm    = i_trans[i];
        o_hwritem    = i_write[i];
        o_hsizem     = i_size[i];
        o_hmasterm   = i_master[i];
        o_hmastlockm = i_mastlock[i];
      end
    end
  end

endmodule

/* hw/ahb_out_arb.sv */
// ----------------------------------------------------------------------
// Fixed-priority arbiter for the shared slave port
// Holds the grant through locked sequences, grant is registered
// ----------------------------------------------------------------------

`timescale 1ns/1ns

module ahb_out_arb
  import ahb_pkg::*, mtx_pkg::*;
(
  input  logic      i_hclk,                       // AHB clock
  input  logic      i_hresetn,                    // Sync reset, active low
  input  logic      i_req [MTX_PORTS],            // Per-port request
  input  logic      i_hready,                     // Muxed HREADY
  input  logic      i_hsel,                       // Muxed HSEL
  input  htrans_t   i_htrans,                     // Muxed HTRANS
  input  logic      i_hmastlock,                  // Muxed HMASTLOCK
  output port_idx_t o_addr_port                   // Address-phase grant
);

  // ----------------------------------------------------------------------
  // Request priority
  // ----------------------------------------------------------------------
  port_idx_t prio_port;                           // Winning requester
  port_idx_t grant_q;                             // Registered grant
  logic      lock_q;                              // Locked sequence seen
  logic      lock_d;                              // Next lock flag
  logic      hlock_arb;                           // Masked lock for hold

  // Scan from the top so the lowest index wins
  always_comb
  begin
    prio_port = PORT_NONE;                        // Default no requester
    for (int i = MTX_PORTS - 1; i >= 0; i--)
    begin
      if (i_req[i])
        prio_port = port_idx_t'(i);               // Lower index overrides
    end
  end

  // ----------------------------------------------------------------------
  // Lock tracking
  // ----------------------------------------------------------------------
  // A master may leave this slave in mid-sequence with HSEL low while
  // still asserting HMASTLOCK, the flag keeps the sequence owned here
  assign lock_d = (i_hsel && i_htrans[1] && i_hmastlock) ? 1'b1 :  // Locked beat starts
                  (!i_hmastlock)                          ? 1'b0 :  // Sequence over
                                                            lock_q; // Keep state

  assign hlock_arb = i_hmastlock & (lock_q | i_hsel);  // Lock only counts when ours

  // ----------------------------------------------------------------------
  // Grant register
  // ----------------------------------------------------------------------
  always_ff @(posedge i_hclk)
  begin
    if (!i_hresetn)
    begin
      grant_q <= PORT_NONE;                       // Nobody owns the slave
      lock_q  <= 1'b0;
    end
    else if (i_hready)                            // Only on completed beats
    begin
      lock_q <= lock_d;
      if (!hlock_arb)
        grant_q <= prio_port;                     // Re-arbitrate
    end
  end

  assign o_addr_port = grant_q;

endmodule

/* hw/ahb_out_data_stage.sv */
// ----------------------------------------------------------------------
// Data-phase port and slave-select registers, HREADY mux, HWDATA mux
// ----------------------------------------------------------------------

`timescale 1ns/1ns

module ahb_out_data_stage
  import ahb_pkg::*, mtx_pkg::*;
(
  input  logic      i_hclk,                       // AHB clock
  input  logic      i_hresetn,                    // Sync reset, active low
  input  port_idx_t i_addr_port,                  // Address-phase grant
  input  logic      i_hselm,                      // Muxed HSEL
  input  logic      i_hreadyoutm,                 // Slave ready feedback
  input  hwdata_t   i_wdata [MTX_PORTS],          // Per-port HWDATA
  output logic      o_hreadymuxm,                 // Muxed HREADY
  output hwdata_t   o_hwdatam                     // Slave write data
);

  port_idx_t data_port_q;                         // Data-phase owner
  logic      slave_sel_q;                         // Slave in data phase
  logic      hready_mux;                          // Transfer completes

  // ----------------------------------------------------------------------
  // Ready generation
  // ----------------------------------------------------------------------
  // Unselected slave is never allowed to stall the bus
  assign hready_mux = slave_sel_q ? i_hreadyoutm : 1'b1;

  // Address phase moves into data phase on each completed beat
  always_ff @(posedge i_hclk)
  begin
    if (!i_hresetn)
    begin
      data_port_q <= PORT_NONE;                   // No write data owner
      slave_sel_q <= 1'b0;
    end
    else if (hready_mux)
    begin
      data_port_q <= i_addr_port;                 // Follow the grant
      slave_sel_q <= i_hselm;
    end
  end

  // ----------------------------------------------------------------------
  // Write data mux
  // ----------------------------------------------------------------------
  always_comb
  begin
    o_hwdatam = '0;                               // Zero under no owner
    for (int i = 0; i < MTX_PORTS; i++)
    begin
      if (data_port_q == port_idx_t'(i))
        o_hwdatam = i_wdata[i];
    end
  end

  assign o_hreadymuxm = hready_mux;

endmodule

/* hw/ahb_out_stage.sv */
// ----------------------------------------------------------------------
// Bus matrix output stage, three input ports onto one slave port
// Joins arbiter, address-phase mux and data-phase stage
// ----------------------------------------------------------------------

`timescale 1ns/1ns

module ahb_out_stage
  import ahb_pkg::*, mtx_pkg::*;
(
  input  logic     HCLK,                          // AHB clock
  input  logic     HRESETn,                       // Sync reset, active low
  input  logic     i_sel       [MTX_PORTS],       // Per-port HSEL
  input  haddr_t   i_addr      [MTX_PORTS],       // Per-port HADDR
  input  htrans_t  i_trans     [MTX_PORTS],       // Per-port HTRANS
  input  logic     i_write     [MTX_PORTS],       // Per-port HWRITE
  input  hsize_t   i_size      [MTX_PORTS],       // Per-port HSIZE
  input  hmaster_t i_master    [MTX_PORTS],       // Per-port HMASTER
  input  logic     i_mastlock  [MTX_PORTS],       // Per-port HMASTLOCK
  input  hwdata_t  i_wdata     [MTX_PORTS],       // Per-port HWDATA
  input  logic     i_held_tran [MTX_PORTS],       // Per-port held transfer
  input  logic     i_hreadyoutm,                  // Slave ready feedback
  output logic     o_active    [MTX_PORTS],       // Port owns address phase
  output logic     o_hselm,                       // Slave select
  output haddr_t   o_haddrm,                      // Slave address
  output htrans_t  o_htransm,                     // Slave transfer type
  output logic     o_hwritem,                     // Slave direction
  output hsize_t   o_hsizem,                      // Slave transfer size
  output hmaster_t o_hmasterm,                    // Slave master ID
  output logic     o_hmastlockm,                  // Slave locked transfer
  output logic     o_hreadymuxm,                  // Muxed HREADY
  output hwdata_t  o_hwdatam                      // Slave write data
);

  logic      req [MTX_PORTS];                     // Arbiter requests
  port_idx_t addr_port;                           // Address-phase grant
  logic      hready_mux;                          // Completed beat

  // A port asks for the slave when it selects it with a pending transfer
  always_comb
  begin
    for (int i = 0; i < MTX_PORTS; i++)
      req[i] = i_sel[i] & i_held_tran[i];
  end

  // ----------------------------------------------------------------------
  // Arbiter, address mux, data stage
  // ----------------------------------------------------------------------
  ahb_out_arb i_ahb_out_arb (
    .i_hclk      (HCLK),
    .i_hresetn   (HRESETn),
    .i_req       (req),
    .i_hready    (hready_mux),
    .i_hsel      (o_hselm),                       // Lock logic sees muxed control
    .i_htrans    (o_htransm),
    .i_hmastlock (o_hmastlockm),
    .o_addr_port (addr_port)
  );

  ahb_out_addr_mux i_ahb_out_addr_mux (
    .i_addr_port  (addr_port),
    .i_sel        (i_sel),
    .i_addr       (i_addr),
    .i_trans      (i_trans),
    .i_write      (i_write),
    .i_size       (i_size),
    .i_master     (i_master),
    .i_mastlock   (i_mastlock),
    .o_active     (o_active),
    .o_hselm      (o_hselm),
    .o_haddrm     (o_haddrm),
    .o_htransm    (o_htransm),
    .o_hwritem    (o_hwritem),
    .o_hsizem     (o_hsizem),
    .o_hmasterm   (o_hmasterm),
    .o_hmastlockm (o_hmastlockm)
  );

  ahb_out_data_stage i_ahb_out_data_stage (
    .i_hclk       (HCLK),
    .i_hresetn    (HRESETn),
    .i_addr_port  (addr_port),
    .i_hselm      (o_hselm),
    .i_hreadyoutm (i_hreadyoutm),
    .i_wdata      (i_wdata),
    .o_hreadymuxm (hready_mux),
    .o_hwdatam    (o_hwdatam)
  );

  assign o_hreadymuxm = hready_mux;               // Also back to the arbiter

endmodule

/* hw/ahb_pkg.sv */
// ----------------------------------------------------------------------
// AHB protocol widths, bus word types and HTRANS transfer codes
// ----------------------------------------------------------------------

package ahb_pkg;

  // ----------------------------------------------------------------------
  // Bus widths
  // ----------------------------------------------------------------------
  localparam int AHB_ADDR_W = 32;                 // HADDR width
  localparam int AHB_DATA_W = 32;                 // HWDATA width

  typedef logic [AHB_ADDR_W-1:0] haddr_t;         // Address word
  typedef logic [AHB_DATA_W-1:0] hwdata_t;        // Write data word
  typedef logic [1:0]            htrans_t;        // Transfer type
  typedef logic [2:0]            hsize_t;         // Transfer size
  typedef logic [3:0]            hmaster_t;       // Master ID

  // ----------------------------------------------------------------------
  // HTRANS codes
  // ----------------------------------------------------------------------
  // Bit 1 high marks a transfer the slave must act on
  localparam htrans_t HTRANS_IDLE   = 2'b00;      // No transfer
  localparam htrans_t HTRANS_BUSY   = 2'b01;      // Burst pause
  localparam htrans_t HTRANS_NONSEQ = 2'b10;      // First beat or single
  localparam htrans_t HTRANS_SEQ    = 2'b11;      // Following burst beat

endpackage

/* hw/mtx_pkg.sv */
// ----------------------------------------------------------------------
// Bus matrix port count, port index type and idle-port code
// ----------------------------------------------------------------------

package mtx_pkg;

  // ----------------------------------------------------------------------
  // Input port numbering
  // ----------------------------------------------------------------------
  localparam int MTX_PORTS = 3;                   // Bus-switch inputs sharing the slave

  // Index 0 is the highest priority input
  typedef logic [1:0] port_idx_t;                 // Input port index

  // Spare code of the index, no input owns the slave
  localparam port_idx_t PORT_NONE = 2'd3;

endpackage

/* tests/ahb_out_stage_props.sv */
// ----------------------------------------------------------------------
// Concurrent assertions bound to the output stage top level
// ----------------------------------------------------------------------

`timescale 1ns/1ns

module ahb_out_stage_props
  import ahb_pkg::*, mtx_pkg::*;
(
  input logic    HCLK,                            // AHB clock
  input logic    HRESETn,                         // Sync active-low reset
  input logic    o_active [MTX_PORTS],            // Per-port grant flags
  input logic    o_hselm,                         // Slave select
  input haddr_t  o_haddrm,                        // Slave address
  input htrans_t o_htransm,                       // Slave transfer type
  input logic    o_hmastlockm,                    // Slave locked transfer
  input logic    o_hreadymuxm                     // Muxed HREADY
);

  int n_fail = 0;                                 // Failed assertion count

  // Selected locked beat keeps its port across the completing edge
  a_lock_hold: assert property (@(posedge HCLK) disable iff (!HRESETn)
    (o_hreadymuxm && o_hselm && o_hmastlockm)
      |=> $stable({o_active[2], o_active[1], o_active[0]}))
    else
    begin
      $error("o_active changed during a locked transfer");
      n_fail = n_fail + 1;
    end

  // Nothing is in data phase right after reset
  a_ready_after_reset: assert property (@(posedge HCLK) $rose(HRESETn) |-> o_hreadymuxm)
    else
    begin
      $error("o_hreadymuxm low after reset");
      n_fail = n_fail + 1;
    end

  a_addr_stable: assert property (@(posedge HCLK) disable iff (!HRESETn)
    !o_hreadymuxm |=> ($stable(o_haddrm) && $stable(o_htransm) && $stable(o_hselm)))
    else
    begin
      $error("Address phase changed during a wait state");
      n_fail = n_fail + 1;
    end

endmodule

bind ahb_out_stage ahb_out_stage_props i_ahb_out_stage_props (
  .HCLK         (HCLK),
  .HRESETn      (HRESETn),
  .o_active     (o_active),
  .o_hselm      (o_hselm),
  .o_haddrm     (o_haddrm),
  .o_htransm    (o_htransm),
  .o_hmastlockm (o_hmastlockm),
  .o_hreadymuxm (o_hreadymuxm)
);

/* tests/tb_ahb_out_stage.sv */
// ----------------------------------------------------------------------
// Output stage testbench with LFSR stimulus and a cycle model
// ----------------------------------------------------------------------

`timescale 1ns/1ns

module tb_ahb_out_stage
  import ahb_pkg::*, mtx_pkg::*;
();

  logic HCLK, HRESETn, i_hreadyoutm;
  logic i_sel [MTX_PORTS], i_write [MTX_PORTS], i_mastlock [MTX_PORTS], i_held_tran [MTX_PORTS];
  haddr_t i_addr [MTX_PORTS];
  htrans_t i_trans [MTX_PORTS];
  hsize_t i_size [MTX_PORTS];
  hmaster_t i_master [MTX_PORTS];
  hwdata_t i_wdata [MTX_PORTS];
  logic o_active [MTX_PORTS];
  logic o_hselm, o_hwritem, o_hmastlockm, o_hreadymuxm;
  haddr_t o_haddrm;
  htrans_t o_htransm;
  hsize_t o_hsizem;
  hmaster_t o_hmasterm;
  hwdata_t o_hwdatam;

  port_idx_t m_grant, m_dport;                    // Model grant and data-phase port
  logic m_lock, m_ssel;                           // Model lock flag and slave select
  logic last_ready = 1'b1;                        // Ready seen at the last edge
  logic [31:0] lfsr = 32'h69c7_4699;              // Stimulus LFSR state
  int errors = 0, n_tests = 0, n_bad = 0, test_err_base = 0;

  ahb_out_stage i_ahb_out_stage (.*);

  initial
  begin
    HCLK = 1'b0;
    forever #50 HCLK = ~HCLK;                     // 100 ns period
  end

  // Galois LFSR stepped once per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      v = {v[30:0], lfsr[0]};                     // Output bit first
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
    end
    return v;
  endfunction

  // Lowest active flag as a port index
  function automatic port_idx_t active_port();
    port_idx_t p;
    p = PORT_NONE;
    for (int i = MTX_PORTS - 1; i >= 0; i--)
      if (o_active[i])
        p = port_idx_t'(i);
    return p;
  endfunction

  // ----------------------------------------------------------------------
  // Compare tasks
  // ----------------------------------------------------------------------
  task automatic report_err(input string name, input logic [31:0] got, input logic [31:0] exp);
    $display("** Error %s: got %h expected %h at %0t", name, got, exp, $time);
    errors++;
  endtask
  task automatic check_port(input string name, input port_idx_t got, input port_idx_t exp);
    if (got !== exp) report_err(name, 32'(got), 32'(exp));
  endtask
  task automatic check_addr(input string name, input haddr_t got, input haddr_t exp);
    if (got !== exp) report_err(name, got, exp);
  endtask
  task automatic check_trans(input string name, input htrans_t got, input htrans_t exp);
    if (got !== exp) report_err(name, 32'(got), 32'(exp));
  endtask
  task automatic check_size(input string name, input hsize_t got, input hsize_t exp);
    if (got !== exp) report_err(name, 32'(got), 32'(exp));
  endtask
  task automatic check_master(input string name, input hmaster_t got, input hmaster_t exp);
    if (got !== exp) report_err(name, 32'(got), 32'(exp));
  endtask
  task automatic check_wdata(input string name, input hwdata_t got, input hwdata_t exp);
    if (got !== exp) report_err(name, got, exp);
  endtask
  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) report_err(name, 32'(got), 32'(exp));
  endtask

  // ----------------------------------------------------------------------
  // Cycle model and stimulus
  // ----------------------------------------------------------------------
  task automatic model_edge();
    logic rdy, hs, act, lk;
    port_idx_t win;
    rdy = m_ssel ? i_hreadyoutm : 1'b1;           // Unselected slave never stalls
    hs  = (m_grant != PORT_NONE) ? i_sel[m_grant] : 1'b0;
    act = (m_grant != PORT_NONE) ? i_trans[m_grant][1] : 1'b0;
    lk  = (m_grant != PORT_NONE) ? i_mastlock[m_grant] : 1'b0;
    win = PORT_NONE;
    for (int i = MTX_PORTS - 1; i >= 0; i--)
      if (i_sel[i] && i_held_tran[i])
        win = port_idx_t'(i);                     // Lowest index wins
    if (!HRESETn)
    begin
      m_grant = PORT_NONE;                        // Nobody granted
      m_dport = PORT_NONE;
      m_lock  = 1'b0;
      m_ssel  = 1'b0;
      rdy     = 1'b1;
    end
    else if (rdy)
    begin
      m_dport = m_grant;                          // Address phase moves to data phase
      m_ssel  = hs;
      if (!(lk && (m_lock || hs)))
        m_grant = win;                            // No lock hold
      if (hs && act && lk)
        m_lock = 1'b1;                            // Locked beat seen
      else if (!lk)
        m_lock = 1'b0;                            // Sequence over
    end
    last_ready = rdy;
  endtask

  task automatic tick();
    @(posedge HCLK);
    model_edge();
    #5;                                           // Drive point
  endtask

  task automatic clear_ports();
    for (int i = 0; i < MTX_PORTS; i++)
    begin
      i_sel[i]       = 1'b0;
      i_write[i]     = 1'b0;
      i_mastlock[i]  = 1'b0;
      i_held_tran[i] = 1'b0;
      i_addr[i]      = '0;
      i_trans[i]     = HTRANS_IDLE;
      i_size[i]      = '0;
      i_master[i]    = '0;
      i_wdata[i]     = '0;
    end
  endtask

  // Masters hold address and data through a wait state
  task automatic drive_random(input logic stalls);
    if (last_ready)
      for (int i = 0; i < MTX_PORTS; i++)
      begin
        i_sel[i]       = 1'(rand_bits(1));
        i_held_tran[i] = 1'(rand_bits(1));
        i_mastlock[i]  = (rand_bits(2) == 32'd0); // Locks kept rare
        i_write[i]     = 1'(rand_bits(1));
        i_trans[i]     = htrans_t'(rand_bits(2));
        i_size[i]      = hsize_t'(rand_bits(3));
        i_master[i]    = hmaster_t'(rand_bits(4));
        i_addr[i]      = rand_bits(32);
        i_wdata[i]     = rand_bits(32);
      end
    i_hreadyoutm = stalls ? 1'(rand_bits(1)) : 1'b1;  // Slave wait states
  endtask

  task automatic check_outputs();
    logic ok_g, ok_d;
    ok_g = (m_grant != PORT_NONE);                // Address phase owned
    ok_d = (m_dport != PORT_NONE);                // Data phase owned
    #45;                                          // Sample mid-cycle where outputs settle
    check_port("o_active", active_port(), m_grant);
    check_bit("o_hselm", o_hselm, ok_g ? i_sel[m_grant] : 1'b0);
    check_addr("o_haddrm", o_haddrm, ok_g ? i_addr[m_grant] : '0);
    check_trans("o_htransm", o_htransm, ok_g ? i_trans[m_grant] : HTRANS_IDLE);
    check_bit("o_hwritem", o_hwritem, ok_g ? i_write[m_grant] : 1'b0);
    check_size("o_hsizem", o_hsizem, ok_g ? i_size[m_grant] : '0);
    check_master("o_hmasterm", o_hmasterm, ok_g ? i_master[m_grant] : '0);
    check_bit("o_hmastlockm", o_hmastlockm, ok_g ? i_mastlock[m_grant] : 1'b0);
    check_bit("o_hreadymuxm", o_hreadymuxm, m_ssel ? i_hreadyoutm : 1'b1);
    check_wdata("o_hwdatam", o_hwdatam, ok_d ? i_wdata[m_dport] : '0);
  endtask

  task automatic wait_ready(input int limit);
    int n;
    n = 0;
    do
    begin
      tick();
      i_hreadyoutm = 1'b1;                        // Slave stops stalling
      check_outputs();
      n++;
    end
    while (!last_ready && n < limit);
    if (!last_ready)
    begin
      $display("Timeout waiting for o_hreadymuxm to return high");
      errors++;
    end
  endtask

  task automatic wait_grant(input port_idx_t p, input int limit);
    int n;
    n = 0;
    do
    begin
      tick();
      check_outputs();
      n++;
    end
    while (!o_active[p] && n < limit);
    if (!o_active[p])
    begin
      $display("Timeout waiting for port %0d to be granted", p);
      errors++;
    end
  endtask

  task automatic end_test(input string name);
    n_tests++;
    if (errors == test_err_base)
      $display("test %s: ok", name);
    else
    begin
      n_bad++;
      $display("test %s: %0d errors", name, errors - test_err_base);
    end
    test_err_base = errors;                       // Next test counts from here
  endtask

  // ----------------------------------------------------------------------
  // Test sequence
  // ----------------------------------------------------------------------
  initial
  begin
    HRESETn = 1'b0;
    i_hreadyoutm = 1'b1;
    clear_ports();
    repeat (3) tick();                            // Reset held 3 cycles
    HRESETn = 1'b1;
    check_outputs();
    check_port("o_active", active_port(), PORT_NONE);
    check_bit("o_hselm", o_hselm, 1'b0);
    check_bit("o_hreadymuxm", o_hreadymuxm, 1'b1);
    end_test("reset state");

    repeat (200)
    begin
      tick();
      drive_random(1'b0);                         // Slave always ready
      check_outputs();
    end
    end_test("priority grant and data phase");

    repeat (300)
    begin
      tick();
      drive_random(1'b1);                         // Random slave wait states
      check_outputs();
    end
    wait_ready(4);
    end_test("wait states");

    // Port 2 opens a locked sequence before ports 0 and 1 compete
    tick();
    clear_ports();
    i_sel[2]       = 1'b1;
    i_held_tran[2] = 1'b1;
    i_trans[2]     = HTRANS_NONSEQ;
    i_mastlock[2]  = 1'b1;
    check_outputs();
    wait_grant(2'd2, 8);
    tick();
    for (int i = 0; i < 2; i++)
    begin
      i_sel[i]       = 1'b1;
      i_held_tran[i] = 1'b1;
      i_trans[i]     = HTRANS_NONSEQ;
    end
    check_outputs();
    repeat (3)
    begin
      tick();
      check_outputs();
      check_port("o_active", active_port(), 2'd2);
    end
    tick();
    i_sel[2] = 1'b0;                              // Leaves the slave with lock still up
    check_outputs();
    check_port("o_active", active_port(), 2'd2);
    repeat (2)
    begin
      tick();
      check_outputs();
      check_port("o_active", active_port(), 2'd2);
    end
    tick();
    i_mastlock[2] = 1'b0;                         // Sequence ends
    check_outputs();
    check_port("o_active", active_port(), 2'd2);
    tick();
    check_outputs();
    check_port("o_active", active_port(), 2'd0);  // Highest priority takes over
    end_test("locked sequence");

    errors += i_ahb_out_stage.i_ahb_out_stage_props.n_fail;
    $display("%0d tests, %0d failed, %0d errors", n_tests, n_bad, errors);
    if (errors == 0)
      $display("All tests passed!");
    else
      $display("Test failures found");
    $finish;
  end

endmodule
